//--- ptw_pkg.sv
/*
 * Sv39 page table walker shared definitions.
 * Address widths, PTE layout, walk level, checker verdict and fault causes.
 */
package ptw_pkg;

    // Sv39 virtual address
    localparam int unsigned VLEN = 39;

    // Physical address and page number
    localparam int unsigned PLEN = 56;
    localparam int unsigned PPNW = 44;

    // Three 9-bit VPN fields
    localparam int unsigned VPNW = 27;

    // IOMMU cause code field
    localparam int unsigned CAUSE_LEN = 12;

    // Sv39 page table entry, msb first
    typedef struct packed {
        logic [9:0]      reserved;
        logic [PPNW-1:0] ppn;
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // Walk level
    // Same encoding gives the page size of an IOTLB update
    // LVL1 is a 1G page, LVL2 a 2M page, LVL3 a 4K page
    typedef enum logic [1:0] {
        LVL1 = 2'd0,
        LVL2 = 2'd1,
        LVL3 = 2'd2
    } level_t;

    // What the checker makes of one PTE
    typedef enum logic [1:0] {
        V_POINTER = 2'd0,
        V_LEAF    = 2'd1,
        V_FAULT   = 2'd2
    } verdict_t;

    // Fault causes reported by the walker
    typedef enum logic [CAUSE_LEN-1:0] {
        LOAD_PAGE_FAULT    = 12'd13,
        STORE_PAGE_FAULT   = 12'd15,
        PT_DATA_CORRUPTION = 12'd274
    } cause_t;

endpackage

//--- ptw_mem_if.sv
/*
 * Walker to memory port read channel.
 * One request and one response in flight, with a ready/valid request handshake.
 */
interface ptw_mem_if import ptw_pkg::*; ();

    // Request side
    logic            req_valid;
    logic            req_ready;
    logic [PLEN-1:0] req_addr;

    // Response side, single-cycle pulse
    logic            rsp_valid;
    pte_t            rsp_pte;
    logic            rsp_err;

    // Walker issues addresses and takes back PTEs
    modport walker (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  rsp_valid,
        input  rsp_pte,
        input  rsp_err
    );

    // Memory port side
    modport port (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output rsp_valid,
        output rsp_pte,
        output rsp_err
    );

endinterface

//--- ptw_mem_port.sv
/*
 * Credited memory port for the page table walker.
 * Tracks read credits, passes requests through and registers responses.
 */
module ptw_mem_port import ptw_pkg::*; #(
    parameter int unsigned MemCredits = 2
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    ptw_mem_if.port         mem,
    output logic            mem_req_valid_o,
    output logic [PLEN-1:0] mem_req_addr_o,
    input  logic            mem_credit_i,
    input  logic            mem_rsp_valid_i,
    input  logic [63:0]     mem_rsp_pte_i,
    input  logic            mem_rsp_err_i
);

    // Counter must hold every value from zero up to MemCredits
    localparam int unsigned CntW = $clog2(MemCredits + 1);

    logic [CntW-1:0] credit_q;
    logic            req_fire;

    // Registered response toward the walker
    logic rsp_valid_q;
    pte_t rsp_pte_q;
    logic rsp_err_q;

    // Accept only while a credit is left
    assign mem.req_ready = (credit_q != '0);
    assign req_fire      = mem.req_valid && mem.req_ready;

    // Request path is combinational
    assign mem_req_valid_o = req_fire;
    assign mem_req_addr_o  = mem.req_addr;

    // Request takes a credit, credit pulse returns one
    // Both in one cycle leave the count unchanged
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credit_q <= CntW'(MemCredits);
        end else begin
            case ({req_fire, mem_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    // Response valid is control, one-cycle delayed
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= mem_rsp_valid_i;
        end
    end

    // Capture PTE and error flag with the response
    always_ff @(posedge clk_i) begin
        if (mem_rsp_valid_i) begin
            rsp_pte_q <= pte_t'(mem_rsp_pte_i);
            rsp_err_q <= mem_rsp_err_i;
        end
    end

    assign mem.rsp_valid = rsp_valid_q;
    assign mem.rsp_pte   = rsp_pte_q;
    assign mem.rsp_err   = rsp_err_q;

endmodule

//--- ptw_pte_check.sv
/*
 * Sv39 PTE checker.
 * Classifies one PTE at a given walk level as pointer, leaf or fault.
 */
module ptw_pte_check import ptw_pkg::*; (
    input  pte_t     pte_i,
    input  level_t   level_i,
    input  logic     is_store_i,
    output verdict_t verdict_o
);

    logic is_leaf;
    logic bad_encoding;
    logic bad_reserved;
    logic bad_pointer;
    logic misaligned;
    logic bad_leaf_perm;
    logic fault;

    // R or X set marks a leaf
    assign is_leaf = pte_i.r || pte_i.x;

    // Not valid, or W without R
    assign bad_encoding = !pte_i.v || (!pte_i.r && pte_i.w);

    // Bits 63:54 must be clear
    assign bad_reserved = |pte_i.reserved;

    // Pointer with A, D or U set, or a pointer where no level is left
    assign bad_pointer = !is_leaf && (pte_i.a || pte_i.d || pte_i.u || (level_i == LVL3));

    // Superpage must be aligned to its own size
    always_comb begin
        case (level_i)
            LVL1:    misaligned = |pte_i.ppn[17:0];
            LVL2:    misaligned = |pte_i.ppn[8:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Leaf needs A and R, and D on a store
    assign bad_leaf_perm = !pte_i.a || !pte_i.r || (is_store_i && !pte_i.d);

    // Any check failing ends the walk
    assign fault = bad_encoding ||
                   bad_reserved ||
                   bad_pointer ||
                   (is_leaf && (misaligned || bad_leaf_perm));

    always_comb begin
        if (fault) begin
            verdict_o = V_FAULT;
        end else if (is_leaf) begin
            verdict_o = V_LEAF;
        end else begin
            verdict_o = V_POINTER;
        end
    end

endmodule

//--- ptw_walker.sv
/*
 * Sv39 walk sequencer.
 * Steps through the page table levels and reports an IOTLB update or a fault.
 */
module ptw_walker import ptw_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            start_i,
    input  logic [VLEN-1:0] iova_i,
    input  logic [PPNW-1:0] root_ppn_i,
    input  logic            is_store_i,
    output logic            busy_o,
    ptw_mem_if.walker       mem,
    output pte_t            pte_o,
    output level_t          level_o,
    input  verdict_t        verdict_i,
    output logic            update_valid_o,
    output logic [VPNW-1:0] update_vpn_o,
    output pte_t            update_pte_o,
    output level_t          update_size_o,
    output logic            fault_valid_o,
    output cause_t          fault_cause_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_REPORT
    } state_e;

    state_e          state_q;
    logic            start_q;
    logic            start_go;
    level_t          level_q;
    level_t          level_next;
    logic            g_q;
    logic            fault_q;
    logic            rsp_take;
    pte_t            leaf_pte;

    // Walk payload
    logic [VLEN-1:0] iova_q;
    logic            store_q;
    logic [PLEN-1:0] ptr_q;
    pte_t            res_pte_q;
    level_t          res_size_q;
    cause_t          res_cause_q;

    // VPN field that indexes the table at a given level
    function automatic logic [8:0] vpn_slice(level_t lvl, logic [VLEN-1:0] va);
        logic [8:0] idx;
        case (lvl)
            LVL1:    idx = va[38:30];
            LVL2:    idx = va[29:21];
            default: idx = va[20:12];
        endcase
        return idx;
    endfunction

    // Busy only while reading memory
    // The report cycle already counts as idle
    assign busy_o   = (state_q == S_REQ) || (state_q == S_WAIT);
    assign start_go = start_i && !start_q && !busy_o;
    assign rsp_take = (state_q == S_WAIT) && mem.rsp_valid;

    // One level down
    always_comb begin
        case (level_q)
            LVL1:    level_next = LVL2;
            default: level_next = LVL3;
        endcase
    end

    // Leaf with G folded in from every PTE on the path
    always_comb begin
        leaf_pte   = mem.rsp_pte;
        leaf_pte.g = g_q || mem.rsp_pte.g;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= S_IDLE;
            start_q <= 1'b0;
            level_q <= LVL1;
            g_q     <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            start_q <= start_i;
            case (state_q)
                S_IDLE, S_REPORT: begin
                    if (start_go) begin
                        state_q <= S_REQ;
                        level_q <= LVL1;
                        g_q     <= 1'b0;
                    end else begin
                        state_q <= S_IDLE;
                    end
                end
                S_REQ: begin
                    // Hold the request until the port has a credit
                    if (mem.req_valid && mem.req_ready) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (mem.rsp_valid) begin
                        if (mem.rsp_err) begin
                            fault_q <= 1'b1;
                            state_q <= S_REPORT;
                        end else begin
                            case (verdict_i)
                                V_POINTER: begin
                                    level_q <= level_next;
                                    g_q     <= g_q || mem.rsp_pte.g;
                                    state_q <= S_REQ;
                                end
                                V_LEAF: begin
                                    fault_q <= 1'b0;
                                    state_q <= S_REPORT;
                                end
                                default: begin
                                    fault_q <= 1'b1;
                                    state_q <= S_REPORT;
                                end
                            endcase
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Walk context and results
    always_ff @(posedge clk_i) begin
        if (start_go) begin
            iova_q  <= iova_i;
            store_q <= is_store_i;
            ptr_q   <= {root_ppn_i, vpn_slice(LVL1, iova_i), 3'b000};
        end
        if (rsp_take) begin
            // Next table entry from this PTE's PPN
            if (!mem.rsp_err && (verdict_i == V_POINTER)) begin
                ptr_q <= {mem.rsp_pte.ppn, vpn_slice(level_next, iova_q), 3'b000};
            end
            res_pte_q   <= leaf_pte;
            res_size_q  <= level_q;
            res_cause_q <= mem.rsp_err ? PT_DATA_CORRUPTION :
                           (store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT);
        end
    end

    assign mem.req_valid = (state_q == S_REQ);
    assign mem.req_addr  = ptr_q;

    // Checker looks at the PTE just returned
    assign pte_o   = mem.rsp_pte;
    assign level_o = level_q;

    // Exactly one result pulse per walk
    assign update_valid_o = (state_q == S_REPORT) && !fault_q;
    assign fault_valid_o  = (state_q == S_REPORT) && fault_q;
    assign update_vpn_o   = iova_q[VLEN-1:12];
    assign update_pte_o   = res_pte_q;
    assign update_size_o  = res_size_q;
    assign fault_cause_o  = res_cause_q;

endmodule

//--- ptw_top.sv
/*
 * Sv39 IOMMU page table walker top level.
 * Connects walker, PTE checker and credited memory port.
 */
module ptw_top import ptw_pkg::*; #(
    parameter int unsigned MemCredits = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 start_i,
    input  logic [VLEN-1:0]      iova_i,
    input  logic [PPNW-1:0]      root_ppn_i,
    input  logic                 is_store_i,
    output logic                 busy_o,
    output logic                 mem_req_valid_o,
    output logic [PLEN-1:0]      mem_req_addr_o,
    input  logic                 mem_credit_i,
    input  logic                 mem_rsp_valid_i,
    input  logic [63:0]          mem_rsp_pte_i,
    input  logic                 mem_rsp_err_i,
    output logic                 update_valid_o,
    output logic [VPNW-1:0]      update_vpn_o,
    output logic [63:0]          update_pte_o,
    output logic [1:0]           update_size_o,
    output logic                 fault_valid_o,
    output logic [CAUSE_LEN-1:0] fault_cause_o
);

    // Walker to checker
    pte_t     chk_pte;
    level_t   chk_level;
    verdict_t chk_verdict;

    ptw_mem_if mem_if ();

    ptw_walker u_walker (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .start_i        (start_i),
        .iova_i         (iova_i),
        .root_ppn_i     (root_ppn_i),
        .is_store_i     (is_store_i),
        .busy_o         (busy_o),
        .mem            (mem_if.walker),
        .pte_o          (chk_pte),
        .level_o        (chk_level),
        .verdict_i      (chk_verdict),
        .update_valid_o (update_valid_o),
        .update_vpn_o   (update_vpn_o),
        .update_pte_o   (update_pte_o),
        .update_size_o  (update_size_o),
        .fault_valid_o  (fault_valid_o),
        .fault_cause_o  (fault_cause_o)
    );

    ptw_pte_check u_pte_check (
        .pte_i      (chk_pte),
        .level_i    (chk_level),
        .is_store_i (is_store_i),
        .verdict_o  (chk_verdict)
    );

    ptw_mem_port #(
        .MemCredits (MemCredits)
    ) u_mem_port (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .mem             (mem_if.port),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_credit_i    (mem_credit_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_pte_i   (mem_rsp_pte_i),
        .mem_rsp_err_i   (mem_rsp_err_i)
    );

endmodule

//--- ptw_properties.sv
/*
 * Bound assertions for the page table walker.
 * Credit use on the read channel and exclusive result pulses.
 */
module ptw_properties #(
    parameter int unsigned MemCredits = 2
) (
    input logic clk_i,
    input logic rst_ni,
    input logic mem_req_valid_i,
    input logic mem_credit_i,
    input logic update_valid_i,
    input logic fault_valid_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Requests sent and not yet paid back by a credit pulse
    int unsigned outstanding_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= 0;
        end else begin
            case ({mem_req_valid_i, mem_credit_i})
                2'b10:   outstanding_q <= outstanding_q + 1;
                2'b01:   outstanding_q <= outstanding_q - 1;
                default: outstanding_q <= outstanding_q;
            endcase
        end
    end

    outstanding_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
        outstanding_q <= MemCredits)
        else $error("more reads outstanding than credits");

    no_request_without_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(mem_req_valid_i && (outstanding_q == MemCredits)))
        else $error("read request with zero credits");

    one_result_kind: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_valid_i && fault_valid_i))
        else $error("update and fault pulse together");

endmodule

// Top level sees both the read channel and the result pulses
bind ptw_top ptw_properties #(
    .MemCredits (MemCredits)
) u_properties (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_credit_i    (mem_credit_i),
    .update_valid_i  (update_valid_o),
    .fault_valid_i   (fault_valid_o)
);

//--- tb_ptw.sv
/*
 * Testbench for the Sv39 IOMMU page table walker.
 * Credited memory model, case file reader and result checks.
 */
module tb_ptw import ptw_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // One credit keeps the port under back-pressure most of the time
    localparam int unsigned MemCredits = 1;
    localparam int unsigned WaitLimit  = 200;

    logic                 clk_i           = 1'b0;
    logic                 rst_ni          = 1'b0;
    logic                 start_i         = 1'b0;
    logic [VLEN-1:0]      iova_i          = '0;
    logic [PPNW-1:0]      root_ppn_i      = '0;
    logic                 is_store_i      = 1'b0;
    logic                 mem_credit_i    = 1'b0;
    logic                 mem_rsp_valid_i = 1'b0;
    logic [63:0]          mem_rsp_pte_i   = '0;
    logic                 mem_rsp_err_i   = 1'b0;
    logic                 busy_o;
    logic                 mem_req_valid_o;
    logic [PLEN-1:0]      mem_req_addr_o;
    logic                 update_valid_o;
    logic [VPNW-1:0]      update_vpn_o;
    logic [63:0]          update_pte_o;
    logic [1:0]           update_size_o;
    logic                 fault_valid_o;
    logic [CAUSE_LEN-1:0] fault_cause_o;

    // Page table image and addresses that answer with an error
    logic [63:0] pt_mem [logic [PLEN-1:0]];
    bit          err_addr [logic [PLEN-1:0]];

    // Walk cases in file order
    logic [VLEN-1:0]      w_iova [$];
    logic [PPNW-1:0]      w_root [$];
    logic                 w_store [$];
    logic                 w_fault [$];
    logic [63:0]          w_pte [$];
    logic [CAUSE_LEN-1:0] w_code [$];

    // Memory model state
    int unsigned     cycle;
    int unsigned     credits;
    int unsigned     rsp_due_q [$];
    logic [PLEN-1:0] rsp_addr_q [$];
    int unsigned     credit_due_q [$];
    int unsigned     results = 0;

    ptw_top #(
        .MemCredits (MemCredits)
    ) dut (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .start_i         (start_i),
        .iova_i          (iova_i),
        .root_ppn_i      (root_ppn_i),
        .is_store_i      (is_store_i),
        .busy_o          (busy_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_credit_i    (mem_credit_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_pte_i   (mem_rsp_pte_i),
        .mem_rsp_err_i   (mem_rsp_err_i),
        .update_valid_o  (update_valid_o),
        .update_vpn_o    (update_vpn_o),
        .update_pte_o    (update_pte_o),
        .update_size_o   (update_size_o),
        .fault_valid_o   (fault_valid_o),
        .fault_cause_o   (fault_cause_o)
    );

    initial begin
        forever #10 clk_i = ~clk_i;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_update(input logic [VPNW-1:0] vpn, input pte_t pte, input level_t size);
        if (update_vpn_o !== vpn) begin
            abort_run($sformatf("** Error update_vpn_o got %h expected %h", update_vpn_o, vpn));
        end
        if (pte_t'(update_pte_o) !== pte) begin
            abort_run($sformatf("** Error update_pte_o got %h expected %h", update_pte_o, pte));
        end
        if (level_t'(update_size_o) !== size) begin
            abort_run($sformatf("** Error update_size_o got %h expected %h",
                                update_size_o, size));
        end
    endtask

    task automatic check_fault(input cause_t cause);
        if (cause_t'(fault_cause_o) !== cause) begin
            abort_run($sformatf("** Error fault_cause_o got %h expected %h",
                                fault_cause_o, cause));
        end
    endtask

    // Reads M, E and W lines and skips comments
    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        string       rest;
        byte         tag;
        logic [63:0] col1;
        logic [63:0] col2;
        logic [63:0] col3;
        logic [63:0] col4;
        logic [63:0] col5;
        logic [63:0] col6;
        fd = $fopen("ptw_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the case file ptw_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 1) begin
                tag  = line.getc(0);
                rest = line.substr(1, line.len() - 1);
                case (tag)
                    "#": begin
                    end
                    "M": begin
                        n = $sscanf(rest, "%h %h", col1, col2);
                        if (n != 2) abort_run("malformed memory line in the case file");
                        pt_mem[col1[PLEN-1:0]] = col2;
                    end
                    "E": begin
                        n = $sscanf(rest, "%h", col1);
                        if (n != 1) abort_run("malformed error line in the case file");
                        err_addr[col1[PLEN-1:0]] = 1'b1;
                    end
                    "W": begin
                        n = $sscanf(rest, "%h %h %h %h %h %h",
                                    col1, col2, col3, col4, col5, col6);
                        if (n != 6) abort_run("malformed walk line in the case file");
                        w_iova.push_back(col1[VLEN-1:0]);
                        w_root.push_back(col2[PPNW-1:0]);
                        w_store.push_back(col3[0]);
                        w_fault.push_back(col4[0]);
                        w_pte.push_back(col5);
                        w_code.push_back(col6[CAUSE_LEN-1:0]);
                    end
                    default: abort_run("unknown line type in the case file");
                endcase
            end
        end
        $fclose(fd);
        if (w_iova.size() == 0) begin
            abort_run("the case file holds no walks");
        end
    endtask

    // One walk from idle with a second start edge while busy
    task automatic run_walk(input int idx);
        int unsigned     waited;
        logic [VLEN-1:0] iova;
        iova   = w_iova[idx];
        waited = 0;
        @(posedge clk_i);
        while (busy_o) begin
            waited++;
            if (waited > WaitLimit) abort_run("walker stayed busy before a new walk");
            @(posedge clk_i);
        end
        iova_i     <= iova;
        root_ppn_i <= w_root[idx];
        is_store_i <= w_store[idx];
        start_i    <= 1'b1;
        @(posedge clk_i);
        start_i <= 1'b0;
        @(posedge clk_i);
        if (!busy_o) abort_run("walker did not go busy after a start edge");
        // This edge must be ignored, so it carries a different walk
        iova_i     <= ~iova;
        root_ppn_i <= ~w_root[idx];
        is_store_i <= ~w_store[idx];
        start_i    <= 1'b1;
        @(posedge clk_i);
        iova_i     <= iova;
        root_ppn_i <= w_root[idx];
        is_store_i <= w_store[idx];
        start_i    <= 1'b0;
        waited = 0;
        @(posedge clk_i);
        while (!(update_valid_o || fault_valid_o)) begin
            waited++;
            if (waited > WaitLimit) abort_run("walk ended with no update and no fault");
            @(posedge clk_i);
        end
        if (w_fault[idx]) begin
            if (!fault_valid_o) abort_run("walk gave an update where a fault was expected");
            check_fault(cause_t'(w_code[idx]));
        end else begin
            if (!update_valid_o) abort_run("walk gave a fault where an update was expected");
            check_update(iova[VLEN-1:12], pte_t'(w_pte[idx]), level_t'(w_code[idx][1:0]));
        end
    endtask

    // Memory model with random response and credit delays
    always @(posedge clk_i) begin
        logic [PLEN-1:0] addr;
        int unsigned     due;
        mem_rsp_valid_i <= 1'b0;
        mem_credit_i    <= 1'b0;
        if (!rst_ni) begin
            cycle   = 0;
            credits = MemCredits;
        end else begin
            cycle++;
            if (mem_req_valid_o) begin
                if (credits == 0) abort_run("read request sent with no credit left");
                credits--;
                rsp_due_q.push_back(cycle + $urandom_range(6, 1));
                rsp_addr_q.push_back(mem_req_addr_o);
            end
            if (mem_credit_i) begin
                credits++;
            end
            if (rsp_due_q.size() != 0 && rsp_due_q[0] == cycle) begin
                void'(rsp_due_q.pop_front());
                addr = rsp_addr_q.pop_front();
                mem_rsp_valid_i <= 1'b1;
                mem_rsp_err_i   <= (err_addr.exists(addr) != 0);
                // Unmapped entries read back as an invalid PTE built from the address
                mem_rsp_pte_i   <= pt_mem.exists(addr) ? pt_mem[addr] : {8'h00, addr};
                // At most one credit pulse per cycle
                due = cycle + $urandom_range(4, 0);
                if (credit_due_q.size() != 0 && due <= credit_due_q[$]) begin
                    due = credit_due_q[$] + 1;
                end
                credit_due_q.push_back(due);
            end
            if (credit_due_q.size() != 0 && credit_due_q[0] == cycle) begin
                void'(credit_due_q.pop_front());
                mem_credit_i <= 1'b1;
            end
        end
    end

    // Count result pulses over the whole run
    always @(posedge clk_i) begin
        if (rst_ni && (update_valid_o || fault_valid_o)) begin
            if (update_valid_o && fault_valid_o) abort_run("update and fault in the same cycle");
            if (busy_o) abort_run("busy still high in the result cycle");
            results++;
        end
    end

    initial begin
        void'($urandom(32'h57c8));
        load_cases();
        repeat (16) @(posedge clk_i);
        if (busy_o || mem_req_valid_o || update_valid_o || fault_valid_o) begin
            abort_run("outputs not low during reset");
        end
        rst_ni <= 1'b1;
        for (int i = 0; i < w_iova.size(); i++) begin
            run_walk(i);
        end
        // Room for any stray result pulse
        repeat (20) @(posedge clk_i);
        if (results != w_iova.size()) begin
            abort_run("number of results differs from the number of walks");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- ptw_cases.txt
# M pt_address pte, E pt_address answers with a memory error (all hex)
# W iova root_ppn store kind(0 update, 1 fault) expected_pte size(0 1G, 1 2M, 2 4K) or cause
M 100008 0000000000040401
M 101010 0000000000040801
M 102018 00000000048d14cf
M 100010 00000000100000cf
M 100018 0000000000040c21
M 103028 00000000000800cf
M 100020 0000000000040400
M 102020 0000000000040801
M 100028 00000000100004cf
M 102028 00000000048d184f
E 100030
E 101030
W 0040403000 100 0 0 00000000048d14cf 2
W 0080001000 100 1 0 00000000100000cf 0
W 00c0a00000 100 0 0 00000000000800ef 1
W 0100000000 100 0 1 0000000000000000 00d
W 0040404000 100 1 1 0000000000000000 00f
W 0140000000 100 0 1 0000000000000000 00d
W 0040405000 100 1 1 0000000000000000 00f
W 0040405000 100 0 0 00000000048d184f 2
W 0180000000 100 1 1 0000000000000000 112
W 0040c00000 100 0 1 0000000000000000 112

//--- sim.f
ptw_pkg.sv
ptw_mem_if.sv
ptw_mem_port.sv
ptw_pte_check.sv
ptw_walker.sv
ptw_top.sv
ptw_properties.sv
tb_ptw.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module tb_ptw -o tb_ptw
	./obj_dir/tb_ptw

clean:
	rm -rf obj_dir
